/* Bender.yml */
package:
  name: mips_lite

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_pkg.sv
      - rtl/mips_alu.sv
      - rtl/mips_regfile.sv
      - rtl/mips_fetch.sv
      - rtl/mips_control.sv
      - rtl/mips_datapath.sv
      - rtl/mips_dmem.sv
      - rtl/mips_core.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/mips_tb.sv

/* mips_lite.f */
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_alu.sv
rtl/mips_regfile.sv
rtl/mips_fetch.sv
rtl/mips_control.sv
rtl/mips_datapath.sv
rtl/mips_dmem.sv
rtl/mips_core.sv
sim/mips_tb.sv

/* rtl/mips_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_alu (
    input  wire  [31:0]             a,
    input  wire  [31:0]             b,
    input  wire  [4:0]              shamt,
    input  wire  mips_pkg::alu_op_e op,
    output logic [31:0]             y,
    output logic                    zero
);

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: y = a + b;
            mips_pkg::ALU_SUB: y = a - b;
            mips_pkg::ALU_AND: y = a & b;
            mips_pkg::ALU_OR:  y = a | b;
            mips_pkg::ALU_XOR: y = a ^ b;
            // Signed compare
            mips_pkg::ALU_SLT: y = {31'd0, $signed(a) < $signed(b)};
            // Shifts move rt by the shamt field
            mips_pkg::ALU_SLL: y = b << shamt;
            mips_pkg::ALU_SRL: y = b >> shamt;
            // Immediate into the upper half
            mips_pkg::ALU_LUI: y = {b[15:0], 16'd0};
            default:           y = a + b;
        endcase
    end

    // Used by beq and bne
    assign zero = (y == 32'd0);

endmodule

`default_nettype wire

/* rtl/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Instruction memory
// Word address width, 64 words
`define IMEM_AW 6

// Data memory
// Word address width, 32 words
`define DMEM_AW 5

// All-zero word
// Decodes as sll r0, r0, 0 and leaves no state behind
`define MIPS_NOP 32'h0000_0000

`endif

/* rtl/mips_control.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_control (
    input  wire  [31:0]                 instruction,
    input  wire                         zero,
    input  wire                         run,
    output mips_pkg::alu_op_e           alu_op,
    output logic                        alu_b_imm,
    output logic                        imm_zero_ext,
    output mips_pkg::wa_sel_e           wa_sel,
    output mips_pkg::result_sel_e       result_sel,
    output mips_pkg::pc_sel_e           pc_sel,
    output logic                        rf_we,
    output logic                        dmem_we
);

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;
    logic              rf_we_d;
    logic              dmem_we_d;

    assign opcode = mips_pkg::opcode_e'(instruction[31:26]);
    assign funct  = mips_pkg::funct_e'(instruction[5:0]);

    //////////////////////////////////////////////////
    // Main decoder
    //////////////////////////////////////////////////

    always_comb begin
        // Defaults give a nop
        alu_op       = mips_pkg::ALU_ADD;
        alu_b_imm    = 1'b0;
        imm_zero_ext = 1'b0;
        wa_sel       = mips_pkg::WA_R0;
        result_sel   = mips_pkg::RES_ALU;
        pc_sel       = mips_pkg::PC_PLUS4;
        rf_we_d      = 1'b0;
        dmem_we_d    = 1'b0;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                wa_sel  = mips_pkg::WA_RD;
                // No write for rd of r0, covers the all-zero nop
                rf_we_d = (instruction[15:11] != 5'd0);
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_JR: begin
                        // Target is rs straight from the register file
                        pc_sel  = mips_pkg::PC_REG;
                        rf_we_d = 1'b0;
                    end
                    default: rf_we_d = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI,
            mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
                alu_b_imm = 1'b1;
                wa_sel    = mips_pkg::WA_RT;
                rf_we_d   = 1'b1;
                case (opcode)
                    mips_pkg::OP_SLTI: alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_LUI:  alu_op = mips_pkg::ALU_LUI;
                    mips_pkg::OP_ANDI: begin
                        alu_op       = mips_pkg::ALU_AND;
                        imm_zero_ext = 1'b1;
                    end
                    mips_pkg::OP_ORI: begin
                        alu_op       = mips_pkg::ALU_OR;
                        imm_zero_ext = 1'b1;
                    end
                    default: alu_op = mips_pkg::ALU_ADD;
                endcase
            end
            mips_pkg::OP_LW: begin
                // Address is rs plus signed offset
                alu_b_imm  = 1'b1;
                wa_sel     = mips_pkg::WA_RT;
                result_sel = mips_pkg::RES_MEM;
                rf_we_d    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                alu_b_imm = 1'b1;
                dmem_we_d = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                // Compare by subtraction
                alu_op = mips_pkg::ALU_SUB;
                if (zero) begin
                    pc_sel = mips_pkg::PC_BRANCH;
                end
            end
            mips_pkg::OP_BNE: begin
                alu_op = mips_pkg::ALU_SUB;
                if (!zero) begin
                    pc_sel = mips_pkg::PC_BRANCH;
                end
            end
            mips_pkg::OP_J: pc_sel = mips_pkg::PC_JUMP;
            mips_pkg::OP_JAL: begin
                pc_sel     = mips_pkg::PC_JUMP;
                wa_sel     = mips_pkg::WA_R31;
                result_sel = mips_pkg::RES_LINK;
                rf_we_d    = 1'b1;
            end
            default: rf_we_d = 1'b0;
        endcase
    end

    // No architectural writes while stopped
    assign rf_we   = rf_we_d & run;
    assign dmem_we = dmem_we_d & run;

    // One destination per instruction
    a_we_excl: assert final (!(rf_we && dmem_we))
        else $error("register and memory write in the same cycle");

endmodule

`default_nettype wire

/* rtl/mips_core.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_cfg.svh"

module mips_core (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 run,
    input  wire                 imem_we,
    input  wire  [`IMEM_AW-1:0] imem_addr,
    input  wire  [31:0]         imem_wdata,
    input  wire  [4:0]          dbg_ra,
    input  wire  [`DMEM_AW-1:0] dbg_maddr,
    output logic [31:0]         pc,
    output logic [31:0]         dbg_rd,
    output logic [31:0]         dbg_mrd
);

    // Decode stage
    logic [31:0]           instruction;
    logic [31:0]           d_pc_plus4;
    // Control
    mips_pkg::alu_op_e     alu_op;
    logic                  alu_b_imm;
    logic                  imm_zero_ext;
    mips_pkg::wa_sel_e     wa_sel;
    mips_pkg::result_sel_e result_sel;
    mips_pkg::pc_sel_e     pc_sel;
    logic                  rf_we;
    logic                  dmem_we;
    // Datapath
    logic                  zero;
    logic [31:0]           alu_out;
    logic [31:0]           store_data;
    logic [31:0]           mem_rdata;
    logic [31:0]           branch_target;
    logic [31:0]           jump_target;
    logic [31:0]           reg_target;

    mips_fetch i_mips_fetch (
        .clock         (clock),
        .rst_n         (rst_n),
        .run           (run),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_wdata    (imem_wdata),
        .pc_sel        (pc_sel),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .reg_target    (reg_target),
        .pc            (pc),
        .instruction   (instruction),
        .d_pc_plus4    (d_pc_plus4)
    );

    mips_control i_mips_control (
        .instruction  (instruction),
        .zero         (zero),
        .run          (run),
        .alu_op       (alu_op),
        .alu_b_imm    (alu_b_imm),
        .imm_zero_ext (imm_zero_ext),
        .wa_sel       (wa_sel),
        .result_sel   (result_sel),
        .pc_sel       (pc_sel),
        .rf_we        (rf_we),
        .dmem_we      (dmem_we)
    );

    mips_datapath i_mips_datapath (
        .clock         (clock),
        .rst_n         (rst_n),
        .instruction   (instruction),
        .d_pc_plus4    (d_pc_plus4),
        .alu_op        (alu_op),
        .alu_b_imm     (alu_b_imm),
        .imm_zero_ext  (imm_zero_ext),
        .wa_sel        (wa_sel),
        .result_sel    (result_sel),
        .rf_we         (rf_we),
        .mem_rdata     (mem_rdata),
        .dbg_ra        (dbg_ra),
        .alu_out       (alu_out),
        .store_data    (store_data),
        .zero          (zero),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .reg_target    (reg_target),
        .dbg_rd        (dbg_rd)
    );

    // Word address, byte offset dropped, upper bits truncated
    mips_dmem i_mips_dmem (
        .clock     (clock),
        .we        (dmem_we),
        .addr      (alu_out[`DMEM_AW+1:2]),
        .wdata     (store_data),
        .dbg_maddr (dbg_maddr),
        .rdata     (mem_rdata),
        .dbg_mrd   (dbg_mrd)
    );

endmodule

`default_nettype wire

/* rtl/mips_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_datapath (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire  [31:0]                 instruction,
    input  wire  [31:0]                 d_pc_plus4,
    input  wire  mips_pkg::alu_op_e     alu_op,
    input  wire                         alu_b_imm,
    input  wire                         imm_zero_ext,
    input  wire  mips_pkg::wa_sel_e     wa_sel,
    input  wire  mips_pkg::result_sel_e result_sel,
    input  wire                         rf_we,
    input  wire  [31:0]                 mem_rdata,
    input  wire  [4:0]                  dbg_ra,
    output logic [31:0]                 alu_out,
    output logic [31:0]                 store_data,
    output logic                        zero,
    output logic [31:0]                 branch_target,
    output logic [31:0]                 jump_target,
    output logic [31:0]                 reg_target,
    output logic [31:0]                 dbg_rd
);

    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [15:0] imm;
    logic [31:0] sign_imm;
    logic [31:0] imm_ext;
    logic [31:0] rd0;
    logic [31:0] rd1;
    logic [31:0] alu_b;
    logic [4:0]  wa;
    logic [31:0] result;

    //////////////////////////////////////////////////
    // Field split and immediate
    //////////////////////////////////////////////////

    assign rs    = instruction[25:21];
    assign rt    = instruction[20:16];
    assign rd    = instruction[15:11];
    assign shamt = instruction[10:6];
    assign imm   = instruction[15:0];

    assign sign_imm = {{16{imm[15]}}, imm};
    // andi and ori take the zero-extended form
    assign imm_ext  = imm_zero_ext ? {16'd0, imm} : sign_imm;

    // Branch offset counts words past the delay slot
    assign branch_target = d_pc_plus4 + {sign_imm[29:0], 2'b00};
    // Upper four bits from the delay slot address
    assign jump_target   = {d_pc_plus4[31:28], instruction[25:0], 2'b00};
    // jr goes to rs
    assign reg_target    = rd0;

    //////////////////////////////////////////////////
    // Register file and ALU
    //////////////////////////////////////////////////

    mips_regfile i_mips_regfile (
        .clock (clock),
        .rst_n (rst_n),
        .we    (rf_we),
        .wa    (wa),
        .wd    (result),
        .ra0   (rs),
        .ra1   (rt),
        .ra2   (dbg_ra),
        .rd0   (rd0),
        .rd1   (rd1),
        .rd2   (dbg_rd)
    );

    assign alu_b      = alu_b_imm ? imm_ext : rd1;
    // sw stores rt
    assign store_data = rd1;

    mips_alu i_mips_alu (
        .a     (rd0),
        .b     (alu_b),
        .shamt (shamt),
        .op    (alu_op),
        .y     (alu_out),
        .zero  (zero)
    );

    //////////////////////////////////////////////////
    // Writeback
    //////////////////////////////////////////////////

    always_comb begin
        case (wa_sel)
            mips_pkg::WA_RT:  wa = rt;
            mips_pkg::WA_RD:  wa = rd;
            mips_pkg::WA_R31: wa = 5'd31;
            default:          wa = 5'd0;
        endcase
    end

    always_comb begin
        case (result_sel)
            mips_pkg::RES_MEM:  result = mem_rdata;
            mips_pkg::RES_LINK: result = d_pc_plus4;
            default:            result = alu_out;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mips_dmem.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_cfg.svh"

module mips_dmem (
    input  wire                 clock,
    input  wire                 we,
    input  wire  [`DMEM_AW-1:0] addr,
    input  wire  [31:0]         wdata,
    input  wire  [`DMEM_AW-1:0] dbg_maddr,
    output logic [31:0]         rdata,
    output logic [31:0]         dbg_mrd
);

    // Word array
    logic [31:0] mem [0:(1 << `DMEM_AW) - 1];

    // Store on the same edge that retires the instruction
    always_ff @(posedge clock) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Load data for writeback in the same cycle
    assign rdata   = mem[addr];
    // Inspection port
    assign dbg_mrd = mem[dbg_maddr];

endmodule

`default_nettype wire

/* rtl/mips_fetch.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_cfg.svh"

module mips_fetch (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     run,
    input  wire                     imem_we,
    input  wire  [`IMEM_AW-1:0]     imem_addr,
    input  wire  [31:0]             imem_wdata,
    input  wire  mips_pkg::pc_sel_e pc_sel,
    input  wire  [31:0]             branch_target,
    input  wire  [31:0]             jump_target,
    input  wire  [31:0]             reg_target,
    output logic [31:0]             pc,
    output logic [31:0]             instruction,
    output logic [31:0]             d_pc_plus4
);

    logic [31:0] imem [0:(1 << `IMEM_AW) - 1];
    logic [31:0] f_instruction;
    logic [31:0] pc_plus4;
    logic [31:0] pc_next;

    //////////////////////////////////////////////////
    // Instruction memory
    //////////////////////////////////////////////////

    // Load port, works with run low too
    always_ff @(posedge clock) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // Word index from the fetch PC
    assign f_instruction = imem[pc[`IMEM_AW+1:2]];

    //////////////////////////////////////////////////
    // Next PC
    //////////////////////////////////////////////////

    assign pc_plus4 = pc + 32'd4;

    // Select comes from the decode-stage instruction
    // so the word fetched now is the delay slot
    always_comb begin
        case (pc_sel)
            mips_pkg::PC_BRANCH: pc_next = branch_target;
            mips_pkg::PC_JUMP:   pc_next = jump_target;
            mips_pkg::PC_REG:    pc_next = reg_target;
            default:             pc_next = pc_plus4;
        endcase
    end

    // PC and decode register
    // Both hold while run is low
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= 32'd0;
            instruction <= `MIPS_NOP;
            d_pc_plus4  <= 32'd0;
        end else if (run) begin
            pc          <= pc_next;
            instruction <= f_instruction;
            d_pc_plus4  <= pc_plus4;
        end
    end

    // Targets from the datapath keep the PC on a word
    a_pc_aligned: assert property (
        @(posedge clock) disable iff (!rst_n) pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // Primary opcodes, instruction bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // Next PC source
    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JUMP,
        PC_REG
    } pc_sel_e;

    // Writeback source, link is decode PC plus 4
    typedef enum logic [1:0] {
        RES_MEM,
        RES_ALU,
        RES_LINK
    } result_sel_e;

    // Register write address
    typedef enum logic [1:0] {
        WA_RT,
        WA_RD,
        WA_R31,
        WA_R0
    } wa_sel_e;

endpackage

`default_nettype wire

/* rtl/mips_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_regfile (
    input  wire         clock,
    input  wire         rst_n,
    input  wire         we,
    input  wire  [4:0]  wa,
    input  wire  [31:0] wd,
    input  wire  [4:0]  ra0,
    input  wire  [4:0]  ra1,
    input  wire  [4:0]  ra2,
    output logic [31:0] rd0,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [0:31];

    // Cleared on reset so debug reads start at zero
    // r0 is never written and stays zero
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Operand ports and debug port
    assign rd0 = regs[ra0];
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    // Write guard keeps r0 at zero over any write sequence
    a_r0_zero: assert property (
        @(posedge clock) disable iff (!rst_n)
            (ra0 != 5'd0 || rd0 == 32'd0) && (ra2 != 5'd0 || rd2 == 32'd0)
    );

endmodule

`default_nettype wire

/* sim/mips_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_cfg.svh"

module mips_tb;

    localparam int PROG_LEN = 48;
    localparam int END_IDX  = 46;

    logic                clock = 1'b0;
    logic                rst_n;
    logic                run;
    logic                imem_we;
    logic [`IMEM_AW-1:0] imem_addr;
    logic [31:0]         imem_wdata;
    logic [4:0]          dbg_ra;
    logic [`DMEM_AW-1:0] dbg_maddr;
    logic [31:0]         pc;
    logic [31:0]         dbg_rd;
    logic [31:0]         dbg_mrd;

    integer      seed = 32'hfe50ad54;
    int          errors = 0;
    bit          timed_out = 1'b0;
    logic [31:0] prog [0:PROG_LEN-1];
    // Instruction-level model state
    logic [31:0] m_regs [0:31];
    logic [31:0] m_mem [0:(1 << `DMEM_AW) - 1];
    bit          m_written [0:(1 << `DMEM_AW) - 1];

    mips_core i_mips_core (
        .clock      (clock),
        .rst_n      (rst_n),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .dbg_ra     (dbg_ra),
        .dbg_maddr  (dbg_maddr),
        .pc         (pc),
        .dbg_rd     (dbg_rd),
        .dbg_mrd    (dbg_mrd)
    );

    always #5 clock = ~clock;

    //////////////////////////////////////////////////
    // Encoding and random helpers
    //////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sh,
                                          input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Random non-control word, destination never r31
    function automatic logic [31:0] gen_data();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [4:0]  w;
        logic [15:0] imm;
        rs  = 5'(rand_below(32));
        rt  = 5'(rand_below(32));
        rd  = 5'(rand_below(31));
        sh  = 5'(rand_below(32));
        w   = 5'(rand_below(32));
        imm = 16'($random(seed));
        case (rand_below(16))
            0:  return enc_r(rs, rt, rd, 5'd0, mips_pkg::FN_ADDU);
            1:  return enc_r(rs, rt, rd, 5'd0, mips_pkg::FN_SUBU);
            2:  return enc_r(rs, rt, rd, 5'd0, mips_pkg::FN_AND);
            3:  return enc_r(rs, rt, rd, 5'd0, mips_pkg::FN_OR);
            4:  return enc_r(rs, rt, rd, 5'd0, mips_pkg::FN_XOR);
            5:  return enc_r(rs, rt, rd, 5'd0, mips_pkg::FN_SLT);
            6:  return enc_r(5'd0, rt, rd, sh, mips_pkg::FN_SLL);
            7:  return enc_r(5'd0, rt, rd, sh, mips_pkg::FN_SRL);
            8:  return enc_i(mips_pkg::OP_ADDIU, rs, rd, imm);
            9:  return enc_i(mips_pkg::OP_ANDI, rs, rd, imm);
            10: return enc_i(mips_pkg::OP_ORI, rs, rd, imm);
            11: return enc_i(mips_pkg::OP_SLTI, rs, rd, imm);
            12: return enc_i(mips_pkg::OP_LUI, 5'd0, rd, imm);
            13: return enc_i(mips_pkg::OP_SW, 5'd0, rt, {9'd0, w, 2'b00});
            14: begin
                // Find a stored word, scan from a random start
                for (int k = 0; k < 32 && !m_written[w]; k++) begin
                    w = w + 5'd1;
                end
                if (!m_written[w]) begin
                    return enc_i(mips_pkg::OP_SW, 5'd0, rt, {9'd0, w, 2'b00});
                end
                // Any base, offset cancels its low seven bits
                imm = 16'({25'd0, w, 2'b00} - (m_regs[rs] & 32'h7f));
                return enc_i(mips_pkg::OP_LW, rs, rd, imm);
            end
            default: return `MIPS_NOP;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Instruction-level model
    //////////////////////////////////////////////////

    function automatic void set_reg(input logic [4:0] r, input logic [31:0] v);
        if (r != 5'd0) begin
            m_regs[r] = v;
        end
    endfunction

    // Executes one word, returns the redirect index or -1
    function automatic int execute(input logic [31:0] word, input int idx);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        int          target;
        rs     = word[25:21];
        rt     = word[20:16];
        a      = m_regs[rs];
        b      = m_regs[rt];
        simm   = {{16{word[15]}}, word[15:0]};
        addr   = a + simm;
        target = -1;
        case (word[31:26])
            mips_pkg::OP_RTYPE: begin
                case (word[5:0])
                    mips_pkg::FN_ADDU: set_reg(word[15:11], a + b);
                    mips_pkg::FN_SUBU: set_reg(word[15:11], a - b);
                    mips_pkg::FN_AND:  set_reg(word[15:11], a & b);
                    mips_pkg::FN_OR:   set_reg(word[15:11], a | b);
                    mips_pkg::FN_XOR:  set_reg(word[15:11], a ^ b);
                    mips_pkg::FN_SLT:  set_reg(word[15:11], ($signed(a) < $signed(b)) ? 1 : 0);
                    mips_pkg::FN_SLL:  set_reg(word[15:11], b << word[10:6]);
                    mips_pkg::FN_SRL:  set_reg(word[15:11], b >> word[10:6]);
                    mips_pkg::FN_JR:   target = int'(a >> 2);
                    default: ;
                endcase
            end
            mips_pkg::OP_ADDIU: set_reg(rt, a + simm);
            mips_pkg::OP_SLTI:  set_reg(rt, ($signed(a) < $signed(simm)) ? 1 : 0);
            mips_pkg::OP_ANDI:  set_reg(rt, a & {16'd0, word[15:0]});
            mips_pkg::OP_ORI:   set_reg(rt, a | {16'd0, word[15:0]});
            mips_pkg::OP_LUI:   set_reg(rt, {word[15:0], 16'd0});
            // Word index is the address above the byte offset
            mips_pkg::OP_LW:    set_reg(rt, m_mem[addr[`DMEM_AW+1:2]]);
            mips_pkg::OP_SW: begin
                m_mem[addr[`DMEM_AW+1:2]]     = b;
                m_written[addr[`DMEM_AW+1:2]] = 1'b1;
            end
            mips_pkg::OP_BEQ: if (a == b) target = idx + 1 + int'($signed(simm));
            mips_pkg::OP_BNE: if (a != b) target = idx + 1 + int'($signed(simm));
            mips_pkg::OP_J:   target = int'(word[25:0]);
            mips_pkg::OP_JAL: begin
                // Link is the delay slot address
                set_reg(5'd31, 32'((idx + 1) * 4));
                target = int'(word[25:0]);
            end
            default: ;
        endcase
        return target;
    endfunction

    // Generates word by word and runs the model alongside
    // Control flow only moves forward so both stay in index order
    task automatic build_program();
        logic [31:0] word;
        int          exec_idx;
        int          redirect;
        int          jr_at;
        int          nt;
        int          pick;
        int          t;
        int          jt;
        bit          have_link;
        exec_idx  = 0;
        redirect  = -1;
        jr_at     = -1;
        have_link = 1'b0;
        for (int r = 0; r < 32; r++) begin
            m_regs[r]    = 32'd0;
            m_written[r] = 1'b0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            pick = rand_below(24);
            t    = i + 2 + rand_below(4);
            if (t > END_IDX) begin
                t = END_IDX;
            end
            jt   = (t < END_IDX) ? t + 1 : END_IDX;
            if (i == END_IDX) begin
                word = {mips_pkg::OP_J, 26'(END_IDX)};
            end else if (i == END_IDX + 1) begin
                word = `MIPS_NOP;
            end else if (i == jr_at) begin
                word = enc_r(5'd31, 5'd0, 5'd0, 5'd0, mips_pkg::FN_JR);
            end else if (i != exec_idx || redirect >= 0 || i > 44) begin
                // Skipped word, delay slot or tail
                word = gen_data();
            end else if (pick < 3) begin
                word = enc_i((pick == 0) ? mips_pkg::OP_BEQ : mips_pkg::OP_BNE,
                             5'(rand_below(4)), 5'(rand_below(4)), 16'(t - i - 1));
            end else if (pick == 3) begin
                word = {mips_pkg::OP_J, 26'(t)};
            end else if (pick == 4) begin
                word      = {mips_pkg::OP_JAL, 26'(t)};
                have_link = 1'b1;
            end else if (pick == 5 && have_link && i <= 43) begin
                // Move the link forward, jr follows
                word  = enc_i(mips_pkg::OP_ADDIU, 5'd31, 5'd31, 16'(jt * 4 - m_regs[31]));
                jr_at = i + 1;
            end else begin
                word = gen_data();
            end
            prog[i] = word;
            if (i == exec_idx) begin
                nt       = execute(word, i);
                exec_idx = (redirect >= 0) ? redirect : i + 1;
                redirect = nt;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Bus tasks and checks
    //////////////////////////////////////////////////

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clock);
            imem_we    <= 1'b1;
            imem_addr  <= i[`IMEM_AW-1:0];
            imem_wdata <= prog[i];
        end
        @(posedge clock);
        imem_we <= 1'b0;
    endtask

    task automatic check_reg(input int r, input logic [31:0] exp);
        @(posedge clock);
        dbg_ra <= r[4:0];
        @(negedge clock);
        if (dbg_rd !== exp) begin
            errors++;
            $display("error: %0t ns: r%0d reads %h, expected %h", $time, r, dbg_rd, exp);
        end
    endtask

    task automatic check_mem(input int w, input logic [31:0] exp);
        @(posedge clock);
        dbg_maddr <= w[`DMEM_AW-1:0];
        @(negedge clock);
        if (dbg_mrd !== exp) begin
            errors++;
            $display("error: %0t ns: word %0d reads %h, expected %h", $time, w, dbg_mrd, exp);
        end
    endtask

    // Forward-only flow, so reaching an address means at or past it
    task automatic wait_pc(input logic [31:0] addr);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (pc < addr && cycles < 200) begin
            @(negedge clock);
            cycles++;
        end
        if (pc < addr) begin
            timed_out = 1'b1;
            $display("Timeout: pc did not reach %h within 200 cycles", addr);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] held;
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        dbg_ra     = '0;
        dbg_maddr  = '0;
        build_program();
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        // Idle core after reset
        @(negedge clock);
        if (pc !== 32'd0) begin
            errors++;
            $display("error: %0t ns: pc is %h after reset, expected 0", $time, pc);
        end
        for (int r = 0; r < 32; r++) begin
            check_reg(r, 32'd0);
        end

        load_program();
        @(posedge clock);
        run <= 1'b1;

        // Stall mid-program for five edges
        wait_pc(32'd40);
        if (!timed_out) begin
            @(posedge clock);
            run <= 1'b0;
            @(negedge clock);
            held = pc;
            for (int c = 0; c < 5; c++) begin
                @(posedge clock);
                if (c == 4) begin
                    run <= 1'b1;
                end
                @(negedge clock);
                if (pc !== held) begin
                    errors++;
                    $display("error: %0t ns: pc moved to %h with run low, held %h",
                             $time, pc, held);
                end
            end
            wait_pc(32'(END_IDX * 4));
        end

        if (!timed_out) begin
            // Last word before the loop and its successor retire
            repeat (2) @(posedge clock);
            for (int r = 0; r < 32; r++) begin
                check_reg(r, m_regs[r]);
            end
            for (int w = 0; w < (1 << `DMEM_AW); w++) begin
                if (m_written[w]) begin
                    check_mem(w, m_mem[w]);
                end
            end
        end

        $display("Errors: %0d, timeouts: %0d", errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
